/* source/xif_pkg.sv */
// Shared widths, types and encodings for the offload subsystem.
// Imported by the core, coprocessor, register block and testbench.
package xif_pkg;

  // Data path widths
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned INSTR_W    = 32;
  localparam int unsigned REG_ADDR_W = 3;
  localparam int unsigned IMM_W      = 16;
  localparam int unsigned CFG_ADDR_W = 2;
  localparam int unsigned NUM_REGS   = 8;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [INSTR_W-1:0]    instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [IMM_W-1:0]      imm_t;
  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

  // Instruction field positions
  localparam int unsigned OPC_MSB = 31;
  localparam int unsigned OPC_LSB = 28;
  localparam int unsigned RD_MSB  = 26;
  localparam int unsigned RD_LSB  = 24;
  localparam int unsigned RS1_MSB = 22;
  localparam int unsigned RS1_LSB = 20;
  localparam int unsigned RS2_MSB = 18;
  localparam int unsigned RS2_LSB = 16;
  localparam int unsigned IMM_MSB = 15;
  localparam int unsigned IMM_LSB = 0;

  // Opcodes not listed here are illegal
  typedef enum logic [3:0] {
    OP_LI     = 4'h0,
    OP_ADD    = 4'h1,
    OP_SUB    = 4'h2,
    OP_XOR    = 4'h3,
    OP_CUSTOM = 4'hB
  } opcode_e;

  // Coprocessor function, taken from imm[1:0]
  typedef enum logic [1:0] {
    CF_MUL  = 2'd0,
    CF_POPC = 2'd1,
    CF_ROTL = 2'd2,
    CF_MAXU = 2'd3
  } copro_func_e;

  // Register block map
  localparam cfg_addr_t CFG_CTRL  = 2'd0;
  localparam cfg_addr_t CFG_COUNT = 2'd1;

endpackage

/* source/xif_regfile.sv */
// General purpose register file of the core.
// Two combinational read ports, one write port applied at the clock edge.
`timescale 1ns/1ps

module xif_regfile (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  xif_pkg::reg_addr_t raddr_a_i,
  input  xif_pkg::reg_addr_t raddr_b_i,
  input  xif_pkg::reg_addr_t waddr_i,
  input  logic               we_i,
  input  xif_pkg::word_t     wdata_i,
  output xif_pkg::word_t     rdata_a_o,
  output xif_pkg::word_t     rdata_b_o
);
  import xif_pkg::*;

  word_t regs_q [NUM_REGS];

  // All registers clear on reset, including index 0
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read ports see the old value during a write cycle
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* source/xif_core.sv */
// Single-issue integer core with one instruction in flight.
// Executes LI/ADD/SUB/XOR locally and offloads CUSTOM to the coprocessor.
// Every instruction leaves through the retire port as a one-cycle pulse.
`timescale 1ns/1ps

module xif_core (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Instruction stream
  input  logic                 instr_valid_i,
  input  xif_pkg::instr_t      instr_i,
  output logic                 instr_ready_o,
  // Register file
  output xif_pkg::reg_addr_t   rf_raddr_a_o,
  output xif_pkg::reg_addr_t   rf_raddr_b_o,
  input  xif_pkg::word_t       rf_rdata_a_i,
  input  xif_pkg::word_t       rf_rdata_b_i,
  output logic                 rf_we_o,
  output xif_pkg::reg_addr_t   rf_waddr_o,
  output xif_pkg::word_t       rf_wdata_o,
  // Offload issue
  output logic                 issue_valid_o,
  output xif_pkg::copro_func_e issue_func_o,
  output xif_pkg::reg_addr_t   issue_rd_o,
  output xif_pkg::word_t       issue_rs1_o,
  output xif_pkg::word_t       issue_rs2_o,
  input  logic                 issue_ready_i,
  input  logic                 issue_accept_i,
  // Offload result
  input  logic                 result_valid_i,
  input  xif_pkg::reg_addr_t   result_rd_i,
  input  xif_pkg::word_t       result_data_i,
  // Retire port
  output logic                 retire_valid_o,
  output xif_pkg::instr_t      retire_instr_o,
  output xif_pkg::reg_addr_t   retire_rd_o,
  output xif_pkg::word_t       retire_data_o,
  output logic                 retire_illegal_o
);
  import xif_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ISSUE,
    WAIT_RESULT
  } core_state_e;

  core_state_e state_q;
  core_state_e state_d;
  instr_t      instr_q;
  logic        ready_q;
  logic        custom_ok_q;
  word_t       result_q;

  opcode_e     opcode;
  reg_addr_t   rd;
  imm_t        imm;
  word_t       alu_res;
  logic        native_op;
  logic        retire_ok;
  logic        instr_fire;
  logic        issue_fire;
  logic        result_hit;

  // Field extraction from the latched instruction
  assign opcode = opcode_e'(instr_q[OPC_MSB:OPC_LSB]);
  assign rd     = instr_q[RD_MSB:RD_LSB];
  assign imm    = instr_q[IMM_MSB:IMM_LSB];

  assign instr_ready_o = ready_q;
  assign instr_fire    = instr_valid_i & ready_q;
  assign issue_fire    = issue_valid_o & issue_ready_i;
  // Result only counts when its tag matches the pending rd
  assign result_hit    = (state_q == WAIT_RESULT) & result_valid_i & (result_rd_i == rd);

  assign rf_raddr_a_o = instr_q[RS1_MSB:RS1_LSB];
  assign rf_raddr_b_o = instr_q[RS2_MSB:RS2_LSB];

  // Native ALU
  always_comb begin
    native_op = 1'b1;
    alu_res   = '0;
    case (opcode)
      OP_LI:   alu_res = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
      OP_ADD:  alu_res = rf_rdata_a_i + rf_rdata_b_i;
      OP_SUB:  alu_res = rf_rdata_a_i - rf_rdata_b_i;
      OP_XOR:  alu_res = rf_rdata_a_i ^ rf_rdata_b_i;
      default: native_op = 1'b0;
    endcase
  end

  // A CUSTOM op in EXEC either came back with a result or was refused
  always_comb begin
    retire_ok     = native_op;
    retire_data_o = alu_res;
    if (opcode == OP_CUSTOM) begin
      retire_ok     = custom_ok_q;
      retire_data_o = result_q;
    end
    if (!retire_ok) begin
      retire_data_o = '0;
    end
  end

  assign retire_valid_o   = (state_q == EXEC);
  assign retire_illegal_o = retire_valid_o & ~retire_ok;
  assign retire_instr_o   = instr_q;
  assign retire_rd_o      = rd;

  // Write back together with retire
  assign rf_we_o    = retire_valid_o & retire_ok;
  assign rf_waddr_o = rd;
  assign rf_wdata_o = retire_data_o;

  // Operands come straight from the register file read ports
  assign issue_valid_o = (state_q == ISSUE);
  assign issue_func_o  = copro_func_e'(imm[1:0]);
  assign issue_rd_o    = rd;
  assign issue_rs1_o   = rf_rdata_a_i;
  assign issue_rs2_o   = rf_rdata_b_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (instr_fire) begin
          state_d = (instr_i[OPC_MSB:OPC_LSB] == OP_CUSTOM) ? ISSUE : EXEC;
        end
      end
      EXEC: state_d = IDLE;
      ISSUE: begin
        if (issue_fire) begin
          state_d = issue_accept_i ? WAIT_RESULT : EXEC;
        end
      end
      WAIT_RESULT: begin
        if (result_hit) begin
          state_d = EXEC;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Ready is registered so it stays low in the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      ready_q     <= 1'b0;
      custom_ok_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == IDLE);
      if (instr_fire) begin
        custom_ok_q <= 1'b0;
      end else if (result_hit) begin
        custom_ok_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_fire) begin
      instr_q <= instr_i;
    end
    if (result_hit) begin
      result_q <= result_data_i;
    end
  end

endmodule

/* source/xif_coprocessor.sv */
// Example coprocessor on the offload interface.
// Accepts work only when enabled; two register stages produce the result.
`timescale 1ns/1ps

module xif_coprocessor (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 copro_en_i,
  // Offload issue
  input  logic                 issue_valid_i,
  input  xif_pkg::copro_func_e issue_func_i,
  input  xif_pkg::reg_addr_t   issue_rd_i,
  input  xif_pkg::word_t       issue_rs1_i,
  input  xif_pkg::word_t       issue_rs2_i,
  output logic                 issue_ready_o,
  output logic                 issue_accept_o,
  // Offload result, no back-pressure
  output logic                 result_valid_o,
  output xif_pkg::reg_addr_t   result_rd_o,
  output xif_pkg::word_t       result_data_o
);
  import xif_pkg::*;

  // Stage 1 holds the captured request
  logic        s1_valid_q;
  copro_func_e s1_func_q;
  reg_addr_t   s1_rd_q;
  word_t       s1_op_a_q;
  word_t       s1_op_b_q;

  // Stage 2 holds the finished result
  logic        s2_valid_q;
  reg_addr_t   s2_rd_q;
  word_t       s2_data_q;

  logic        take;
  word_t       op_res;
  logic [2*WORD_W-1:0] rot_tmp;

  function automatic word_t popcount(word_t val);
    word_t cnt;
    cnt = '0;
    for (int i = 0; i < WORD_W; i++) begin
      cnt = cnt + word_t'(val[i]);
    end
    return cnt;
  endfunction

  assign issue_ready_o  = ~s1_valid_q & ~s2_valid_q;
  assign issue_accept_o = copro_en_i;
  assign take           = issue_valid_i & issue_ready_o & copro_en_i;

  // Rotate via the upper half of a doubled word
  assign rot_tmp = {s1_op_a_q, s1_op_a_q} << s1_op_b_q[4:0];

  always_comb begin
    op_res = '0;
    case (s1_func_q)
      CF_MUL:  op_res = s1_op_a_q * s1_op_b_q;
      CF_POPC: op_res = popcount(s1_op_a_q);
      CF_ROTL: op_res = rot_tmp[2*WORD_W-1:WORD_W];
      CF_MAXU: op_res = (s1_op_a_q > s1_op_b_q) ? s1_op_a_q : s1_op_b_q;
      default: op_res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= take;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      s1_func_q <= issue_func_i;
      s1_rd_q   <= issue_rd_i;
      s1_op_a_q <= issue_rs1_i;
      s1_op_b_q <= issue_rs2_i;
    end
    if (s1_valid_q) begin
      s2_rd_q   <= s1_rd_q;
      s2_data_q <= op_res;
    end
  end

  assign result_valid_o = s2_valid_q;
  assign result_rd_o    = s2_rd_q;
  assign result_data_o  = s2_data_q;

endmodule

/* source/xif_cfg_regs.sv */
// Software-visible control block beside the coprocessor.
// Holds the enable bit and counts offloads the coprocessor accepted.
`timescale 1ns/1ps

module xif_cfg_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Register bus
  input  logic                cfg_we_i,
  input  xif_pkg::cfg_addr_t  cfg_addr_i,
  input  xif_pkg::word_t      cfg_wdata_i,
  output xif_pkg::word_t      cfg_rdata_o,
  // Issue handshake monitor
  input  logic                issue_valid_i,
  input  logic                issue_ready_i,
  input  logic                issue_accept_i,
  output logic                copro_en_o
);
  import xif_pkg::*;

  logic  en_q;
  word_t count_q;
  logic  accepted;

  assign accepted = issue_valid_i & issue_ready_i & issue_accept_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      count_q <= '0;
    end else begin
      if (cfg_we_i && (cfg_addr_i == CFG_CTRL)) begin
        en_q <= cfg_wdata_i[0];
      end
      // Writing the count address clears it, data is ignored
      if (cfg_we_i && (cfg_addr_i == CFG_COUNT)) begin
        count_q <= '0;
      end else if (accepted) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      CFG_CTRL:  cfg_rdata_o = {{(WORD_W-1){1'b0}}, en_q};
      CFG_COUNT: cfg_rdata_o = count_q;
      default:   cfg_rdata_o = '0;
    endcase
  end

  assign copro_en_o = en_q;

endmodule

/* source/xif_subsystem.sv */
// Top level of the offload subsystem.
// Places the core and register file beside the coprocessor and its control block.
`timescale 1ns/1ps

module xif_subsystem (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Instruction stream
  input  logic               instr_valid_i,
  input  xif_pkg::instr_t    instr_i,
  output logic               instr_ready_o,
  // Retire trace
  output logic               retire_valid_o,
  output xif_pkg::instr_t    retire_instr_o,
  output xif_pkg::reg_addr_t retire_rd_o,
  output xif_pkg::word_t     retire_data_o,
  output logic               retire_illegal_o,
  // Register bus
  input  logic               cfg_we_i,
  input  xif_pkg::cfg_addr_t cfg_addr_i,
  input  xif_pkg::word_t     cfg_wdata_i,
  output xif_pkg::word_t     cfg_rdata_o
);
  import xif_pkg::*;

  reg_addr_t   rf_raddr_a;
  reg_addr_t   rf_raddr_b;
  word_t       rf_rdata_a;
  word_t       rf_rdata_b;
  logic        rf_we;
  reg_addr_t   rf_waddr;
  word_t       rf_wdata;

  logic        issue_valid;
  copro_func_e issue_func;
  reg_addr_t   issue_rd;
  word_t       issue_rs1;
  word_t       issue_rs2;
  logic        issue_ready;
  logic        issue_accept;

  logic        result_valid;
  reg_addr_t   result_rd;
  word_t       result_data;

  logic        copro_en;

  xif_core i_core (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .instr_valid_i    ( instr_valid_i    ),
    .instr_i          ( instr_i          ),
    .instr_ready_o    ( instr_ready_o    ),
    .rf_raddr_a_o     ( rf_raddr_a       ),
    .rf_raddr_b_o     ( rf_raddr_b       ),
    .rf_rdata_a_i     ( rf_rdata_a       ),
    .rf_rdata_b_i     ( rf_rdata_b       ),
    .rf_we_o          ( rf_we            ),
    .rf_waddr_o       ( rf_waddr         ),
    .rf_wdata_o       ( rf_wdata         ),
    .issue_valid_o    ( issue_valid      ),
    .issue_func_o     ( issue_func       ),
    .issue_rd_o       ( issue_rd         ),
    .issue_rs1_o      ( issue_rs1        ),
    .issue_rs2_o      ( issue_rs2        ),
    .issue_ready_i    ( issue_ready      ),
    .issue_accept_i   ( issue_accept     ),
    .result_valid_i   ( result_valid     ),
    .result_rd_i      ( result_rd        ),
    .result_data_i    ( result_data      ),
    .retire_valid_o   ( retire_valid_o   ),
    .retire_instr_o   ( retire_instr_o   ),
    .retire_rd_o      ( retire_rd_o      ),
    .retire_data_o    ( retire_data_o    ),
    .retire_illegal_o ( retire_illegal_o )
  );

  xif_regfile i_regfile (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .waddr_i   ( rf_waddr   ),
    .we_i      ( rf_we      ),
    .wdata_i   ( rf_wdata   ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b )
  );

  xif_coprocessor i_coprocessor (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .copro_en_i     ( copro_en     ),
    .issue_valid_i  ( issue_valid  ),
    .issue_func_i   ( issue_func   ),
    .issue_rd_i     ( issue_rd     ),
    .issue_rs1_i    ( issue_rs1    ),
    .issue_rs2_i    ( issue_rs2    ),
    .issue_ready_o  ( issue_ready  ),
    .issue_accept_o ( issue_accept ),
    .result_valid_o ( result_valid ),
    .result_rd_o    ( result_rd    ),
    .result_data_o  ( result_data  )
  );

  // Enable and offload counter sit on the issue handshake
  xif_cfg_regs i_cfg_regs (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .cfg_we_i       ( cfg_we_i     ),
    .cfg_addr_i     ( cfg_addr_i   ),
    .cfg_wdata_i    ( cfg_wdata_i  ),
    .cfg_rdata_o    ( cfg_rdata_o  ),
    .issue_valid_i  ( issue_valid  ),
    .issue_ready_i  ( issue_ready  ),
    .issue_accept_i ( issue_accept ),
    .copro_en_o     ( copro_en     )
  );

endmodule

/* dv/tb_clock_gen.sv */
// Free-running clock for the testbench, 20 ns period.
// Starts low, so the first rising edge is at 10 ns.
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    // Half of the 20 ns period
    forever #10ns clk_o = ~clk_o;
  end

endmodule

/* dv/xif_subsystem_tb.sv */
// Testbench for the offload subsystem.
// Sends a random instruction stream, checks every retire against an architectural
// model and checks the register block over its bus. Ends with a count line.
`timescale 1ns/1ps

module xif_subsystem_tb;
  import xif_pkg::*;

  localparam int N_NATIVE  = 200;
  localparam int N_REFUSED = 40;
  localparam int N_CUSTOM  = 200;
  localparam int N_ILLEGAL = 30;
  localparam int N_LONG    = 2000;
  localparam int N_CHUNKS  = 4;
  // Timeout allows 20 cycles per instruction plus a margin for reset and bus accesses
  localparam int TOTAL_INSTR    = N_NATIVE + 3*N_REFUSED + 2*N_CUSTOM + 6*N_ILLEGAL + N_LONG;
  localparam int TIMEOUT_CYCLES = 20*TOTAL_INSTR + 1000;

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  instr_t    instr;
  logic      instr_ready;
  logic      retire_valid;
  instr_t    retire_instr;
  reg_addr_t retire_rd;
  word_t     retire_data;
  logic      retire_illegal;
  logic      cfg_we;
  cfg_addr_t cfg_addr;
  word_t     cfg_wdata;
  word_t     cfg_rdata;

  // Architectural model
  word_t     model_regs [NUM_REGS];
  logic      model_en;
  int        model_count;
  instr_t    sent_q [$];

  int        sent_cnt;
  int        retired_cnt;
  int        check_cnt;
  int        err_cnt;
  int        cycle_cnt;

  tb_clock_gen i_clock_gen (
    .clk_o ( clk )
  );

  xif_subsystem i_xif_subsystem (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .instr_valid_i    ( instr_valid    ),
    .instr_i          ( instr          ),
    .instr_ready_o    ( instr_ready    ),
    .retire_valid_o   ( retire_valid   ),
    .retire_instr_o   ( retire_instr   ),
    .retire_rd_o      ( retire_rd      ),
    .retire_data_o    ( retire_data    ),
    .retire_illegal_o ( retire_illegal ),
    .cfg_we_i         ( cfg_we         ),
    .cfg_addr_i       ( cfg_addr       ),
    .cfg_wdata_i      ( cfg_wdata      ),
    .cfg_rdata_o      ( cfg_rdata      )
  );

  function automatic instr_t make_instr(logic [3:0] op, reg_addr_t rd, reg_addr_t rs1,
                                        reg_addr_t rs2, logic [15:0] imm);
    instr_t ins;
    ins = '0;
    ins[OPC_MSB:OPC_LSB] = op;
    ins[RD_MSB:RD_LSB]   = rd;
    ins[RS1_MSB:RS1_LSB] = rs1;
    ins[RS2_MSB:RS2_LSB] = rs2;
    ins[IMM_MSB:IMM_LSB] = imm;
    return ins;
  endfunction

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'($urandom_range(NUM_REGS-1));
  endfunction

  function automatic instr_t rand_native();
    logic [3:0] ops [4];
    ops = '{OP_LI, OP_ADD, OP_SUB, OP_XOR};
    return make_instr(ops[$urandom_range(3)], rand_reg(), rand_reg(), rand_reg(),
                      16'($urandom));
  endfunction

  function automatic logic [3:0] rand_illegal_op();
    logic [3:0] op;
    do begin
      op = 4'($urandom_range(15));
    end while (op inside {OP_LI, OP_ADD, OP_SUB, OP_XOR, OP_CUSTOM});
    return op;
  endfunction

  function automatic instr_t rand_custom(reg_addr_t rd, logic [1:0] func);
    logic [15:0] imm;
    imm      = 16'($urandom);
    imm[1:0] = func;
    return make_instr(OP_CUSTOM, rd, rand_reg(), rand_reg(), imm);
  endfunction

  // Roughly 6 native, 3 custom and 1 illegal out of 10
  function automatic instr_t rand_any();
    int unsigned pick;
    pick = $urandom_range(9);
    if (pick < 6) begin
      return rand_native();
    end else if (pick < 9) begin
      return rand_custom(rand_reg(), 2'($urandom_range(3)));
    end
    return make_instr(rand_illegal_op(), rand_reg(), rand_reg(), rand_reg(), 16'($urandom));
  endfunction

  function automatic word_t custom_result(logic [1:0] func, word_t a, word_t b);
    word_t       res;
    int unsigned sh;
    res = '0;
    case (func)
      CF_MUL:  res = a * b;
      CF_POPC: begin
        for (int i = 0; i < 32; i++) begin
          if (a[i]) res = res + 1;
        end
      end
      CF_ROTL: begin
        sh  = b[4:0];
        res = (sh == 0) ? a : ((a << sh) | (a >> (32 - sh)));
      end
      default: res = (a > b) ? a : b;
    endcase
    return res;
  endfunction

  task automatic compare_word(input string what, input word_t got, input word_t exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_retire(input instr_t ins);
    logic [3:0]  op;
    reg_addr_t   rd;
    logic [15:0] imm;
    word_t       a;
    word_t       b;
    word_t       exp;
    logic        exp_ill;
    op      = ins[OPC_MSB:OPC_LSB];
    rd      = ins[RD_MSB:RD_LSB];
    imm     = ins[IMM_MSB:IMM_LSB];
    a       = model_regs[ins[RS1_MSB:RS1_LSB]];
    b       = model_regs[ins[RS2_MSB:RS2_LSB]];
    exp     = '0;
    exp_ill = 1'b0;
    case (op)
      OP_LI:  exp = {{16{imm[15]}}, imm};
      OP_ADD: exp = a + b;
      OP_SUB: exp = a - b;
      OP_XOR: exp = a ^ b;
      OP_CUSTOM: begin
        if (model_en) begin
          exp = custom_result(imm[1:0], a, b);
          model_count++;
        end else begin
          exp_ill = 1'b1;
        end
      end
      default: exp_ill = 1'b1;
    endcase
    compare_word("retire_instr", retire_instr, ins);
    compare_word("retire_rd", word_t'(retire_rd), word_t'(rd));
    compare_word("retire_illegal", word_t'(retire_illegal), word_t'(exp_ill));
    // Illegal instructions write nothing, so their data is not defined
    if (!exp_ill) begin
      compare_word("retire_data", retire_data, exp);
      model_regs[rd] = exp;
    end
  endtask

  task automatic send_instr(input instr_t ins, input int unsigned gap);
    repeat (gap) begin
      @(negedge clk);
      instr_valid = 1'b0;
      instr       = instr_t'($urandom);
    end
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = ins;
    do begin
      @(posedge clk);
    end while (!instr_ready);
    sent_q.push_back(ins);
    sent_cnt++;
  endtask

  // Wait until every instruction sent so far has retired
  task automatic drain();
    @(negedge clk);
    instr_valid = 1'b0;
    while (sent_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Zero a spare register, send the instruction, then read rd back with ADD
  task automatic send_with_readback(input instr_t ins);
    reg_addr_t rd;
    reg_addr_t zr;
    rd = ins[RD_MSB:RD_LSB];
    do begin
      zr = rand_reg();
    end while (zr == rd);
    send_instr(make_instr(OP_LI, zr, 3'd0, 3'd0, 16'd0), 0);
    send_instr(ins, 0);
    send_instr(make_instr(OP_ADD, rd, rd, zr, 16'd0), 0);
  endtask

  task automatic write_cfg(input cfg_addr_t addr, input word_t data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  task automatic read_cfg(input cfg_addr_t addr, output word_t data);
    @(negedge clk);
    cfg_we   = 1'b0;
    cfg_addr = addr;
    @(posedge clk);
    data = cfg_rdata;
  endtask

  // Only bit 0 of the written word should matter
  task automatic set_enable(input logic en);
    word_t w;
    w    = $urandom;
    w[0] = en;
    write_cfg(CFG_CTRL, w);
    model_en = en;
  endtask

  // Every retire pulse is counted, also one with nothing outstanding
  always @(posedge clk) begin
    if (rst_n && retire_valid) begin
      retired_cnt++;
      assert (sent_q.size() != 0) else begin
        err_cnt++;
        $display("Retire at %0t with no instruction outstanding", $time);
      end
      if (sent_q.size() != 0) begin
        check_retire(sent_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions retired",
               cycle_cnt, retired_cnt, sent_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    word_t data;
    void'($urandom(32'h75a39d00));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    cfg_we      = 1'b0;
    cfg_addr    = CFG_CTRL;
    cfg_wdata   = '0;
    model_en    = 1'b0;
    model_count = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Reset state of the handshake and the register block
    @(posedge clk);
    compare_word("instr_ready after reset", word_t'(instr_ready), '0);
    compare_word("retire_valid after reset", word_t'(retire_valid), '0);
    read_cfg(CFG_CTRL, data);
    compare_word("CTRL after reset", data, '0);
    read_cfg(CFG_COUNT, data);
    compare_word("COUNT after reset", data, '0);

    // Native instructions with the coprocessor off
    for (int i = 0; i < N_NATIVE; i++) begin
      send_instr(rand_native(), 0);
    end
    drain();

    // Refused offloads leave rd untouched
    for (int i = 0; i < N_REFUSED; i++) begin
      send_with_readback(rand_custom(rand_reg(), 2'(i % 4)));
    end
    drain();

    // Enabled coprocessor, all four functions
    set_enable(1'b1);
    read_cfg(CFG_CTRL, data);
    compare_word("CTRL after enable", data, 32'd1);
    for (int i = 0; i < N_CUSTOM; i++) begin
      send_instr(rand_native(), 0);
      send_instr(rand_custom(rand_reg(), 2'(i % 4)), 0);
    end
    drain();

    // Unknown opcodes, first enabled then disabled
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < N_ILLEGAL; i++) begin
        send_with_readback(make_instr(rand_illegal_op(), rand_reg(), rand_reg(), rand_reg(),
                                      16'($urandom)));
      end
      drain();
      set_enable(1'b0);
    end

    // Offload counter and its clear
    read_cfg(CFG_COUNT, data);
    compare_word("COUNT", data, word_t'(model_count));
    write_cfg(CFG_COUNT, $urandom);
    model_count = 0;
    read_cfg(CFG_COUNT, data);
    compare_word("COUNT after clear", data, '0);

    // Long mixed stream with gaps, enable flipped between chunks
    for (int c = 0; c < N_CHUNKS; c++) begin
      set_enable(c % 2 == 0);
      for (int i = 0; i < N_LONG / N_CHUNKS; i++) begin
        send_instr(rand_any(), $urandom_range(3));
      end
      drain();
    end
    read_cfg(CFG_COUNT, data);
    compare_word("COUNT after stream", data, word_t'(model_count));
    compare_word("retired count", word_t'(retired_cnt), word_t'(sent_cnt));

    $display("Summary: %0d instructions retired, %0d checks, %0d errors",
             retired_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
source/xif_pkg.sv
source/xif_regfile.sv
source/xif_core.sv
source/xif_coprocessor.sv
source/xif_cfg_regs.sv
source/xif_subsystem.sv
dv/tb_clock_gen.sv
dv/xif_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the offload subsystem testbench
# Example: make run BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= xif_subsystem_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --assert -Wno-fatal -j 0
PASS_TEXT  ?= *** PASSED ***

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line appears in the simulation output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
